/* src/axi_pkg.sv */
package axi_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_size_t AXI_SIZE_BYTE = 3'h0;
    localparam axi_size_t AXI_SIZE_HALF = 3'h1;
    localparam axi_size_t AXI_SIZE_WORD = 3'h2;

    localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
    localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

    typedef struct packed {
        axi_addr_t addr;
        axi_size_t size;
    } axi_aw_t;

    typedef struct packed {
        axi_addr_t addr;
        axi_size_t size;
    } axi_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;    // single beat, no last flag
    } axi_w_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

endpackage

/* src/lsu_pkg.sv */
package lsu_pkg;

    // one-hot access width, zero means no access
    typedef logic [2:0] mem_width_t;

    localparam mem_width_t MEM_BYTE = 3'b001;
    localparam mem_width_t MEM_HALF = 3'b010;
    localparam mem_width_t MEM_WORD = 3'b100;

    // execute stage payload
    typedef struct packed {
        axi_pkg::axi_addr_t addr;
        axi_pkg::axi_data_t wdata;
    } ex_to_lsu_t;

    // decode stage control
    typedef struct packed {
        mem_width_t load_width;
        mem_width_t store_width;
        logic       load_unsigned;
        logic       is_load;
        logic       is_store;
    } dec_to_lsu_t;

    typedef struct packed {
        axi_pkg::axi_addr_t addr;
        axi_pkg::axi_data_t data;     // raw word, aligned later
        mem_width_t         load_width;
        logic               load_unsigned;
    } lsu_to_wb_t;

    localparam axi_pkg::axi_addr_t SRAM_BASE  = 32'h8000_0000;
    localparam int                 SRAM_WORDS = 256;

endpackage

/* src/lsu.sv */
`timescale 1ns/1ns
module lsu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exu_valid,
    input  logic                 wbu_ready,
    output logic                 lsu_ready,
    output logic                 lsu_valid,
    input  lsu_pkg::ex_to_lsu_t  ex_in,
    input  lsu_pkg::dec_to_lsu_t dec_in,
    output lsu_pkg::lsu_to_wb_t  wb_out,
    output logic                 access_fault,

    input  logic                 aw_ready,
    output logic                 aw_valid,
    output axi_pkg::axi_aw_t     aw,
    input  logic                 w_ready,
    output logic                 w_valid,
    output axi_pkg::axi_w_t      w,
    output logic                 b_ready,
    input  logic                 b_valid,
    input  axi_pkg::axi_b_t      b,
    input  logic                 ar_ready,
    output logic                 ar_valid,
    output axi_pkg::axi_ar_t     ar,
    output logic                 r_ready,
    input  logic                 r_valid,
    input  axi_pkg::axi_r_t      r
);
    import axi_pkg::*;
    import lsu_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } lsu_state_t;

    lsu_state_t  state;
    logic        launch;        // first busy cycle, issue the operation
    ex_to_lsu_t  op_ex;
    dec_to_lsu_t op_dec;
    axi_data_t   data_q;
    logic [1:0]  off;

    function automatic axi_size_t width_to_size(input mem_width_t width);
        case (width)
            MEM_BYTE: return AXI_SIZE_BYTE;
            MEM_HALF: return AXI_SIZE_HALF;
            default:  return AXI_SIZE_WORD;
        endcase
    endfunction

    assign lsu_ready = (state == IDLE);
    assign off       = op_ex.addr[1:0];

    // request payloads come straight from the held operation
    assign ar.addr = op_ex.addr;
    assign ar.size = width_to_size(op_dec.load_width);
    assign aw.addr = op_ex.addr;
    assign aw.size = width_to_size(op_dec.store_width);
    assign w.data  = op_ex.wdata << {off, 3'b000};   // move into byte lane

    always_comb begin
        case (op_dec.store_width)
            MEM_BYTE: w.strb = axi_strb_t'(4'b0001 << off);
            MEM_HALF: w.strb = axi_strb_t'(4'b0011 << off);
            MEM_WORD: w.strb = 4'b1111;
            default:  w.strb = 4'b0000;
        endcase
    end

    assign wb_out.addr          = op_ex.addr;
    assign wb_out.data          = data_q;
    assign wb_out.load_width    = op_dec.is_load ? op_dec.load_width : '0;
    assign wb_out.load_unsigned = op_dec.load_unsigned;

    always_ff @(posedge clk) begin
        if (lsu_ready && exu_valid) begin
            op_ex  <= ex_in;
            op_dec <= dec_in;
        end
        if (state == BUSY && launch) begin
            data_q <= (op_dec.is_load || op_dec.is_store) ? '0 : op_ex.addr;
        end
        if (r_valid && r_ready) begin
            data_q <= r.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            launch       <= 1'b0;
            lsu_valid    <= 1'b0;
            access_fault <= 1'b0;
            aw_valid     <= 1'b0;
            w_valid      <= 1'b0;
            b_ready      <= 1'b0;
            ar_valid     <= 1'b0;
            r_ready      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (exu_valid) begin
                        state  <= BUSY;
                        launch <= 1'b1;
                    end
                end
                BUSY: begin
                    if (launch) begin
                        launch <= 1'b0;
                        if (op_dec.is_load) begin
                            ar_valid <= 1'b1;
                        end else if (op_dec.is_store) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                        end else begin
                            lsu_valid <= 1'b1;  // address passthrough
                        end
                    end
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (r_valid && r_ready) begin
                        r_ready      <= 1'b0;
                        lsu_valid    <= 1'b1;
                        access_fault <= (r.resp != AXI_RESP_OKAY);
                    end
                    if (aw_valid && aw_ready && w_valid && w_ready) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b0;
                        b_ready  <= 1'b1;
                    end
                    if (b_valid && b_ready) begin
                        b_ready      <= 1'b0;
                        lsu_valid    <= 1'b1;
                        access_fault <= (b.resp != AXI_RESP_OKAY);
                    end
                    if (lsu_valid && wbu_ready) begin   // result taken
                        lsu_valid    <= 1'b0;
                        access_fault <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* src/load_align.sv */
`timescale 1ns/1ns
module load_align (
    input  lsu_pkg::lsu_to_wb_t wb_in,
    output axi_pkg::axi_data_t  wb_data
);
    import axi_pkg::*;
    import lsu_pkg::*;

    logic [1:0]  off;
    axi_data_t   shifted;
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    assign off      = wb_in.addr[1:0];
    assign shifted  = wb_in.data >> {off, 3'b000};  // lane down to bit 0
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        case (wb_in.load_width)
            MEM_BYTE: begin
                if (wb_in.load_unsigned) begin
                    wb_data = {24'h0, byte_val};
                end else begin
                    wb_data = {{24{byte_val[7]}}, byte_val};
                end
            end
            MEM_HALF: begin
                if (wb_in.load_unsigned) begin
                    wb_data = {16'h0, half_val};
                end else begin
                    wb_data = {{16{half_val[15]}}, half_val};
                end
            end
            default: wb_data = wb_in.data;  // word load or no access
        endcase
    end

endmodule

/* src/axi_sram.sv */
`timescale 1ns/1ns
module axi_sram (
    input  logic             clk,
    input  logic             rst,
    output logic             aw_ready,
    input  logic             aw_valid,
    input  axi_pkg::axi_aw_t aw,
    output logic             w_ready,
    input  logic             w_valid,
    input  axi_pkg::axi_w_t  w,
    input  logic             b_ready,
    output logic             b_valid,
    output axi_pkg::axi_b_t  b,
    output logic             ar_ready,
    input  logic             ar_valid,
    input  axi_pkg::axi_ar_t ar,
    input  logic             r_ready,
    output logic             r_valid,
    output axi_pkg::axi_r_t  r
);
    import axi_pkg::*;
    import lsu_pkg::*;

    localparam int        IDX_W      = $clog2(SRAM_WORDS);
    localparam axi_addr_t SRAM_BYTES = 32'(SRAM_WORDS * 4);

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_READY,
        CH_RESP
    } ch_state_t;

    ch_state_t  rd_state;
    ch_state_t  wr_state;
    axi_data_t  mem [SRAM_WORDS];
    axi_addr_t  rd_off;
    axi_addr_t  wr_off;
    logic       rd_hit;
    logic       wr_hit;
    logic       wr_fire;

    // offset from base, wraps below base so one compare decodes
    assign rd_off = ar.addr - SRAM_BASE;
    assign wr_off = aw.addr - SRAM_BASE;
    assign rd_hit = (rd_off < SRAM_BYTES);
    assign wr_hit = (wr_off < SRAM_BYTES);

    assign ar_ready = (rd_state == CH_READY);
    assign r_valid  = (rd_state == CH_RESP);
    assign aw_ready = (wr_state == CH_READY);
    assign w_ready  = (wr_state == CH_READY);
    assign b_valid  = (wr_state == CH_RESP);
    assign wr_fire  = aw_valid && w_valid && aw_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= CH_IDLE;
            wr_state <= CH_IDLE;
        end else begin
            case (rd_state)
                CH_IDLE:  if (ar_valid) rd_state <= CH_READY;
                CH_READY: if (ar_valid) rd_state <= CH_RESP;
                CH_RESP:  if (r_ready) rd_state <= CH_IDLE;
                default:  rd_state <= CH_IDLE;
            endcase
            case (wr_state)
                CH_IDLE:  if (aw_valid && w_valid) wr_state <= CH_READY;
                CH_READY: if (wr_fire) wr_state <= CH_RESP;
                CH_RESP:  if (b_ready) wr_state <= CH_IDLE;
                default:  wr_state <= CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r.data <= rd_hit ? mem[rd_off[IDX_W+1:2]] : '0;
            r.resp <= rd_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        if (wr_fire) begin
            b.resp <= wr_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[wr_off[IDX_W+1:2]][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

/* src/lsu_top.sv */
`timescale 1ns/1ns
module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exu_valid,
    output logic                 lsu_ready,
    input  lsu_pkg::ex_to_lsu_t  ex_in,
    input  lsu_pkg::dec_to_lsu_t dec_in,
    output logic                 lsu_valid,
    input  logic                 wbu_ready,
    output axi_pkg::axi_addr_t   wb_addr,
    output axi_pkg::axi_data_t   wb_data,
    output logic                 access_fault
);
    import axi_pkg::*;
    import lsu_pkg::*;

    logic       aw_valid, aw_ready;
    axi_aw_t    aw;
    logic       w_valid, w_ready;
    axi_w_t     w;
    logic       b_valid, b_ready;
    axi_b_t     b;
    logic       ar_valid, ar_ready;
    axi_ar_t    ar;
    logic       r_valid, r_ready;
    axi_r_t     r;
    lsu_to_wb_t wb_out;

    assign wb_addr = wb_out.addr;

    // port names match the channel wires
    lsu lsu_i (.*);

    load_align load_align_i (
        .wb_in   (wb_out),
        .wb_data (wb_data)
    );

    axi_sram axi_sram_i (.*);

endmodule

/* testbench/lsu_tb.sv */
`timescale 1ns/1ns
module lsu_tb;
    import axi_pkg::*;
    import lsu_pkg::*;

    localparam int CLK_NS     = 40;
    localparam int RST_CYCLES = 16;
    localparam int RAND_ITERS = 100;
    localparam int MAX_OPS    = 400;   // watchdog budget, generous per op
    localparam int OP_CYCLES  = 40;

    logic        clk;
    logic        rst;
    logic        exu_valid;
    logic        lsu_ready;
    ex_to_lsu_t  ex_in;
    dec_to_lsu_t dec_in;
    logic        lsu_valid;
    logic        wbu_ready;
    axi_addr_t   wb_addr;
    axi_data_t   wb_data;
    logic        access_fault;

    logic [7:0]  shadow [SRAM_WORDS*4];   // byte image of the SRAM
    integer      seed;
    axi_addr_t   exp_addr;
    axi_data_t   exp_data;
    logic        exp_fault;
    logic        check_data;
    logic        held;                    // result was refused at the last edge
    axi_data_t   held_data;
    logic        held_fault;

    lsu_top lsu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((RST_CYCLES + MAX_OPS * OP_CYCLES) * CLK_NS);
        $display("watchdog expired, the DUT stopped finishing operations");
        fail_now();
    end

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, expected, actual);
        fail_now();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    always @(posedge clk) begin
        held       <= lsu_valid && !wbu_ready;
        held_data  <= wb_data;
        held_fault <= access_fault;
    end

    assert property (@(negedge clk) disable iff (rst)
        lsu_valid |-> (access_fault == exp_fault))
        else report_mismatch("access_fault", 32'(exp_fault), 32'(access_fault));
    assert property (@(negedge clk) disable iff (rst)
        lsu_valid |-> (wb_addr == exp_addr))
        else report_mismatch("wb_addr", exp_addr, wb_addr);
    assert property (@(negedge clk) disable iff (rst)
        (lsu_valid && check_data) |-> (wb_data == exp_data))
        else report_mismatch("wb_data", exp_data, wb_data);
    assert property (@(negedge clk) disable iff (rst)
        held |-> (lsu_valid && !lsu_ready))
        else report_mismatch("{lsu_valid,lsu_ready}", 32'h2, 32'({lsu_valid, lsu_ready}));
    assert property (@(negedge clk) disable iff (rst)
        held |-> (wb_data == held_data))
        else report_mismatch("wb_data (held)", held_data, wb_data);
    assert property (@(negedge clk) disable iff (rst)
        held |-> (access_fault == held_fault))
        else report_mismatch("access_fault (held)", 32'(held_fault), 32'(access_fault));

    function automatic axi_data_t fill_word(input axi_addr_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic axi_data_t shadow_load(input axi_addr_t addr, input mem_width_t width,
                                              input logic uns);
        int idx;
        idx = int'(addr - SRAM_BASE);
        case (width)
            MEM_BYTE: return uns ? {24'h0, shadow[idx]} : {{24{shadow[idx][7]}}, shadow[idx]};
            MEM_HALF: return uns ? {16'h0, shadow[idx+1], shadow[idx]}
                                 : {{16{shadow[idx+1][7]}}, shadow[idx+1], shadow[idx]};
            default:  return {shadow[idx+3], shadow[idx+2], shadow[idx+1], shadow[idx]};
        endcase
    endfunction

    function automatic void shadow_store(input axi_addr_t addr, input axi_data_t data,
                                         input mem_width_t width);
        int idx;
        int n;
        idx = int'(addr - SRAM_BASE);
        n   = (width == MEM_BYTE) ? 1 : (width == MEM_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            shadow[idx + i] = data[8*i +: 8];   // lowest bytes land at addr upward
        end
    endfunction

    function automatic mem_width_t rand_width();
        case ($unsigned($random(seed)) % 3)
            0:       return MEM_BYTE;
            1:       return MEM_HALF;
            default: return MEM_WORD;
        endcase
    endfunction

    // aligned address inside the SRAM window
    function automatic axi_addr_t rand_addr(input mem_width_t width);
        logic [31:0] r;
        axi_addr_t   a;
        r = $random(seed);
        a = SRAM_BASE + r % (SRAM_WORDS * 4);
        if (width == MEM_HALF) begin
            a[0] = 1'b0;
        end else if (width == MEM_WORD) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    function automatic dec_to_lsu_t make_dec(input logic load, input logic store,
                                             input mem_width_t width, input logic uns);
        dec_to_lsu_t d;
        d.load_width    = load ? width : '0;
        d.store_width   = store ? width : '0;
        d.load_unsigned = uns;
        d.is_load       = load;
        d.is_store      = store;
        return d;
    endfunction

    // one operation through both handshakes, called at a falling edge
    task automatic run_op(input axi_addr_t addr, input axi_data_t wdata, input dec_to_lsu_t dec,
                          input logic check, input axi_data_t exp_d, input logic exp_f);
        int hold;
        hold = $unsigned($random(seed)) % 8;
        check_value("lsu_ready", 32'(lsu_ready), 32'h1);
        exp_addr   = addr;
        exp_data   = exp_d;
        exp_fault  = exp_f;
        check_data = check;
        ex_in.addr  = addr;
        ex_in.wdata = wdata;
        dec_in      = dec;
        exu_valid   = 1'b1;
        wbu_ready   = (hold == 0);   // zero hold means no back-pressure
        @(negedge clk);
        exu_valid = 1'b0;
        while (!lsu_valid) @(negedge clk);
        repeat (hold) @(negedge clk);
        wbu_ready = 1'b1;
        @(negedge clk);
        wbu_ready = 1'b0;
    endtask

    task automatic do_store(input axi_addr_t addr, input axi_data_t data,
                            input mem_width_t width, input logic in_range);
        run_op(addr, data, make_dec(1'b0, 1'b1, width, 1'b0), 1'b0, '0, !in_range);
        if (in_range) begin
            shadow_store(addr, data, width);
        end
    endtask

    task automatic do_load(input axi_addr_t addr, input mem_width_t width, input logic uns,
                           input logic in_range);
        axi_data_t exp_word;
        exp_word = in_range ? shadow_load(addr, width, uns) : '0;   // error reads give zero
        run_op(addr, '0, make_dec(1'b1, 1'b0, width, uns), 1'b1, exp_word, !in_range);
    endtask

    initial begin
        int         kind;
        axi_addr_t  addr;
        mem_width_t width;
        axi_data_t  data;
        seed       = 61627;
        rst        = 1'b1;
        exu_valid  = 1'b0;
        wbu_ready  = 1'b0;
        ex_in      = '0;
        dec_in     = '0;
        exp_addr   = '0;
        exp_data   = '0;
        exp_fault  = 1'b0;
        check_data = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("lsu_ready", 32'(lsu_ready), 32'h1);
        check_value("lsu_valid", 32'(lsu_valid), 32'h0);
        check_value("access_fault", 32'(access_fault), 32'h0);

        for (int i = 0; i < SRAM_WORDS; i++) begin   // known contents everywhere
            addr = SRAM_BASE + 32'(i * 4);
            do_store(addr, fill_word(addr), MEM_WORD, 1'b1);
        end

        for (int n = 0; n < RAND_ITERS; n++) begin
            kind  = $unsigned($random(seed)) % 8;
            width = rand_width();
            addr  = rand_addr(width);
            data  = $random(seed);
            case (kind)
                0: begin
                    addr = rand_addr(MEM_WORD);
                    do_store(addr, data, MEM_WORD, 1'b1);
                    do_load(addr, MEM_WORD, 1'b0, 1'b1);
                end
                1, 2: do_store(addr, data, width, 1'b1);
                3, 4: do_load(addr, width, data[0], 1'b1);
                5: run_op(data, '0, make_dec(1'b0, 1'b0, '0, 1'b0), 1'b1, data, 1'b0);
                6: begin
                    do_store(addr + SRAM_WORDS * 4, data, width, 1'b0);   // alias above window
                    do_load(addr & ~32'h3, MEM_WORD, 1'b0, 1'b1);
                end
                default: do_load({1'b0, addr[30:0]}, width, data[0], 1'b0);
            endcase
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* lsu_subsys.f */
src/axi_pkg.sv
src/lsu_pkg.sv
src/lsu.sv
src/load_align.sv
src/axi_sram.sv
src/lsu_top.sv
testbench/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert --top-module lsu_tb -Mdir obj_dir -o lsu_sim \
    -f lsu_subsys.f \
    && ./obj_dir/lsu_sim | awk '{ print } /Result: PASSED/ { found = 1 } END { exit !found }' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
